// File: hdl/ngp_video_defs.svh
////////////////////////////////////////
// timing constants and memory map for
// the handheld console video subsystem.
////////////////////////////////////////
`ifndef NGP_VIDEO_DEFS_SVH
`define NGP_VIDEO_DEFS_SVH

`define NGP_HTOTAL_LAST 514   // last tick of a line, so a line is 515 ticks.
`define NGP_HBSTART     14    // horizontal blanking starts here.
`define NGP_HBEND       49    // and ends here, 35 ticks later.
`define NGP_HS_START    22    // horizontal sync rises, line events happen here too.
`define NGP_HS_END      26    // horizontal sync falls.

`define NGP_VLAST       198   // last line, so a frame is 199 lines.
`define NGP_VBSTART     151   // vertical blanking starts after this line.
`define NGP_VS_START    180   // vertical sync rises after this line.
`define NGP_VS_END      183   // vertical sync falls after this line.
`define NGP_HIRQ_LAST   149   // horizontal interrupts stop after this line.

`define NGP_VIS_W       160   // visible pixels per line.
`define NGP_VIS_H       152   // visible lines per frame.

`define NGP_MAP_BASE    0     // word base of the 32x32 tile map.
`define NGP_PAT_BASE    2048  // word base of the tile patterns, 8 words per tile.
`define NGP_PAL_SEL_BIT 12    // cpu address bit that selects the palette.

`endif

// File: hdl/ngp_timing_pkg.sv
////////////////////////////////////////
// types for pixel coordinates, colour
// and the video timer state.
////////////////////////////////////////
`default_nettype none

package ngp_timing_pkg;

    typedef logic [8:0] hpos_t;   // pixel column, counts past the visible width.
    typedef logic [7:0] vpos_t;   // line number within a frame.

    typedef logic [9:0] hcnt_t;   // horizontal tick counter, 515 ticks per line.
    typedef logic [2:0] phase_t;  // one-hot phase of the divide-by-three.

    // 4 bits per primary, red in the top nibble.
    typedef struct packed {
        logic [3:0] r;            // red level.
        logic [3:0] g;            // green level.
        logic [3:0] b;            // blue level.
    } color_t;

endpackage

`default_nettype wire

// File: hdl/ngp_vram_pkg.sv
////////////////////////////////////////
// types for video memory words, map
// entries, pattern rows and pixel indices.
////////////////////////////////////////
`default_nettype none

package ngp_vram_pkg;

    typedef logic [11:0] vram_addr_t;  // word address into the 4096-word memory.

    // one tile map entry, tile number in the low byte.
    typedef struct packed {
        logic [1:0] spare;             // unused by the plane.
        logic       vflip;             // mirror the tile top to bottom.
        logic       hflip;             // mirror the tile left to right.
        logic [3:0] pal;               // palette number for the whole tile.
        logic [7:0] tile;              // pattern number, 0 to 255.
    } map_entry_t;

    // eight 2-bit pixels, element 7 is the leftmost pixel.
    typedef logic [7:0][1:0] pat_row_t;

    // the memory does not know what it holds.
    // the plane decodes a word as a map entry or as a pattern row,
    // depending on which fetch slot it was read in.
    typedef union packed {
        map_entry_t map;               // view used for map fetches.
        pat_row_t   pat;               // view used for pattern fetches.
    } vram_word_t;

    // palette lookup index, 4 colours per palette.
    typedef struct packed {
        logic [3:0] pal;               // palette number from the map entry.
        logic [1:0] pix;               // pixel value from the pattern.
    } pal_index_t;

endpackage

`default_nettype wire

// File: hdl/ngp_timing_if.sv
////////////////////////////////////////
// timing bus from the video timer to
// the scroll plane and the palette.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface ngp_timing_if ();
    import ngp_timing_pkg::*;

    logic  pxl_cen;   // one-clock pixel enable.
    hpos_t hdump;     // current pixel column, valid at pxl_cen.
    vpos_t vdump;     // current line, steps at horizontal sync start.
    logic  lhbl;      // low during horizontal blanking.
    logic  lvbl;      // low during vertical blanking.

    modport timer (
        output pxl_cen,
        output hdump,
        output vdump,
        output lhbl,
        output lvbl
    );

    modport sink (
        input pxl_cen,
        input hdump,
        input vdump,
        input lhbl,
        input lvbl
    );

endinterface

`default_nettype wire

// File: hdl/ngp_vtimer.sv
////////////////////////////////////////
// video timer with tick and line counters,
// pixel enable, blanking, sync and irqs.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_vtimer (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   video_cen,   // one tick of the video clock.
    input  wire logic   hint_en,     // horizontal interrupt enable, plain level.
    input  wire logic   vint_en,     // vertical interrupt enable, plain level.
    ngp_timing_if.timer tim,
    output logic        HS,
    output logic        VS,
    output logic        hirq,
    output logic        virq
);
    import ngp_timing_pkg::*;

    hcnt_t  hcnt;      // tick within the line, 0 to 514.
    phase_t three;     // rotates once per tick, pixel on bit 2.
    vpos_t  vrender;   // line being rendered, one ahead of vdump.

    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt        <= '0;
            three       <= 3'b001;
            vrender     <= '0;
            tim.pxl_cen <= 1'b0;
            tim.hdump   <= '0;
            tim.vdump   <= '0;
            tim.lhbl    <= 1'b1;
            tim.lvbl    <= 1'b1;
            HS          <= 1'b0;
            VS          <= 1'b0;
            hirq        <= 1'b0;
            virq        <= 1'b0;
        end else begin
            tim.pxl_cen <= video_cen & three[2];  // a pixel every third tick.
            if (video_cen) begin
                three <= {three[1:0], three[2]};
                if (hcnt == 10'd6) begin          // both interrupts drop early in the line.
                    hirq <= 1'b0;
                    virq <= 1'b0;
                end
                if (hcnt == `NGP_HBSTART) tim.lhbl <= 1'b0;
                if (hcnt == `NGP_HBEND) tim.lhbl <= 1'b1;
                if (hcnt == `NGP_HTOTAL_LAST) begin
                    hcnt        <= '0;
                    three       <= 3'b001;        // the phase restarts with every line.
                    tim.hdump   <= '0;
                    tim.pxl_cen <= 1'b1;          // column 0 gets its own strobe.
                end else begin
                    hcnt <= hcnt + 10'd1;
                    if (three[2]) tim.hdump <= tim.hdump + 9'd1;
                end
                if (hcnt == `NGP_HS_END) HS <= 1'b0;
                if (hcnt == `NGP_HS_START) begin
                    HS        <= 1'b1;
                    vrender   <= (vrender == `NGP_VLAST) ? 8'd0 : vrender + 8'd1;
                    tim.vdump <= vrender;
                    // the line checks below look at vdump before it steps.
                    virq <= vint_en && (tim.vdump == `NGP_VBSTART);
                    hirq <= hint_en && (tim.vdump <= `NGP_HIRQ_LAST ||
                                        tim.vdump == `NGP_VLAST);
                    if (tim.vdump == `NGP_VBSTART) begin
                        tim.lvbl <= 1'b0;
                    end else if (tim.vdump == `NGP_VLAST) begin
                        tim.lvbl <= 1'b1;         // blanking ends as line 0 comes up.
                    end
                    if (tim.vdump == `NGP_VS_START) begin
                        VS <= 1'b1;
                    end else if (tim.vdump == `NGP_VS_END) begin
                        VS <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ngp_vram.sv
////////////////////////////////////////
// video memory, cpu write port and
// registered video read port.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_vram (
    input  wire logic                       clk,
    input  wire logic                       cpu_we,
    input  wire logic [`NGP_PAL_SEL_BIT:0]  cpu_addr,
    input  wire logic [15:0]                cpu_din,
    input  wire logic                       rd_en,
    input  wire ngp_vram_pkg::vram_addr_t   rd_addr,
    output ngp_vram_pkg::vram_word_t        rd_data
);
    import ngp_vram_pkg::*;

    vram_word_t mem [0:(1 << $bits(vram_addr_t)) - 1];  // map and patterns share it.
    logic       cpu_sel;                                // write aimed at this half.

    assign cpu_sel = cpu_we && !cpu_addr[`NGP_PAL_SEL_BIT];

    always_ff @(posedge clk) begin
        if (cpu_sel) begin
            mem[cpu_addr[`NGP_PAL_SEL_BIT-1:0]] <= cpu_din;  // visible on the next clock.
        end
    end

    // the read data holds between reads, so the plane can use it late.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/ngp_scroll_plane.sv
////////////////////////////////////////
// scroll plane with map and pattern fetch
// sequencer and an 8-pixel shifter.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_scroll_plane (
    input  wire logic                     clk,
    input  wire logic                     reset,
    ngp_timing_if.sink                    tim,
    output logic                          rd_en,
    output ngp_vram_pkg::vram_addr_t      rd_addr,
    input  wire ngp_vram_pkg::vram_word_t rd_data,
    output ngp_vram_pkg::pal_index_t      pxl_out
);
    import ngp_timing_pkg::*;
    import ngp_vram_pkg::*;

    vpos_t      line_q;     // line the fetches are made for.
    logic       prefetch;   // past the visible width, fetch column 0 of the next line.
    logic [4:0] col;        // tile column for the map fetch.
    logic [2:0] fine;       // pattern row within the tile.
    logic       map_rd;     // map fetch slot, first pixel of a group.
    logic       pat_rd;     // pattern fetch slot, second pixel of a group.
    logic       map_pend;   // map entry arrives this cycle.
    logic       pat_pend;   // pattern row arrives this cycle.
    map_entry_t map_q;      // entry of the tile being fetched.
    pat_row_t   pat_flip;   // incoming row in mirrored order.
    pat_row_t   next_row;   // row waiting for the next group.
    logic [3:0] next_pal;   // its palette number.
    pat_row_t   cur_row;    // shifter, leftmost pixel in element 7.
    logic [3:0] cur_pal;    // palette of the group on screen.

    assign prefetch = tim.hdump > `NGP_VIS_W;
    assign col      = prefetch ? 5'd0 : tim.hdump[7:3] + 5'd1;  // always one tile ahead.
    assign fine     = map_q.vflip ? ~line_q[2:0] : line_q[2:0];
    assign map_rd   = tim.pxl_cen && (tim.hdump[2:0] == 3'd0);
    assign pat_rd   = tim.pxl_cen && (tim.hdump[2:0] == 3'd1);
    assign rd_en    = map_rd | pat_rd;

    // map is 32 words per tile row, patterns are 8 words per tile.
    assign rd_addr = map_rd ? vram_addr_t'(`NGP_MAP_BASE + {line_q[7:3], col})
                            : vram_addr_t'(`NGP_PAT_BASE + {map_q.tile, fine});

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pat_flip[i] = rd_data.pat[7-i];  // swap left and right pixels.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            line_q   <= '0;
            map_pend <= 1'b0;
            pat_pend <= 1'b0;
        end else begin
            map_pend <= map_rd;
            pat_pend <= pat_rd;
            // vdump has already stepped by now and stays put until the line ends.
            if (tim.pxl_cen && tim.hdump == `NGP_VIS_W + 1) line_q <= tim.vdump;
        end
    end

    always_ff @(posedge clk) begin
        if (map_pend) map_q <= rd_data.map;  // same word, seen as a map entry.
        if (pat_pend) begin
            next_row <= map_q.hflip ? pat_flip : rd_data.pat;
            next_pal <= map_q.pal;
        end
    end

    always_ff @(posedge clk) begin
        if (tim.pxl_cen) begin
            if (tim.hdump[2:0] == 3'd0) begin
                cur_row <= next_row;                  // start of a new group.
                cur_pal <= next_pal;
            end else begin
                cur_row <= {cur_row[6:0], 2'b00};     // next pixel moves to the top.
            end
        end
    end

    assign pxl_out = {cur_pal, cur_row[7]};

endmodule

`default_nettype wire

// File: hdl/ngp_palette.sv
////////////////////////////////////////
// palette memory and colour output with
// display area and matched position.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_palette (
    input  wire logic                      clk,
    input  wire logic                      cpu_we,
    input  wire logic [`NGP_PAL_SEL_BIT:0] cpu_addr,
    input  wire logic [15:0]               cpu_din,
    ngp_timing_if.sink                     tim,
    input  wire ngp_vram_pkg::pal_index_t  pxl_in,
    output ngp_timing_pkg::color_t         rgb,
    output ngp_timing_pkg::hpos_t          pix_x,
    output ngp_timing_pkg::vpos_t          pix_y,
    output logic                           de
);
    import ngp_timing_pkg::*;

    color_t pal_mem [0:63];  // 16 palettes of 4 colours.
    vpos_t  line_q;          // line on screen, vdump steps partway through it.
    logic   in_area;         // the pixel arriving from the plane is visible.

    always_ff @(posedge clk) begin
        if (cpu_we && cpu_addr[`NGP_PAL_SEL_BIT]) begin
            pal_mem[cpu_addr[5:0]] <= cpu_din[11:0];  // top data nibble is ignored.
        end
    end

    // the plane output lags hdump by one pixel, so columns 1 to 160 are shown.
    assign in_area = (tim.hdump != 9'd0) && (tim.hdump <= `NGP_VIS_W) &&
                     (line_q < `NGP_VIS_H);

    always_ff @(posedge clk) begin
        if (tim.pxl_cen) begin
            if (tim.hdump == 9'd0) line_q <= tim.vdump;  // latched once per line.
            pix_x <= tim.hdump - 9'd1;
            pix_y <= line_q;
            de    <= in_area;
            rgb   <= in_area ? pal_mem[pxl_in] : '0;     // black outside the screen.
        end
    end

endmodule

`default_nettype wire

// File: hdl/ngp_video.sv
////////////////////////////////////////
// video subsystem top level with timer,
// memory, scroll plane and palette.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_video (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      video_cen,
    input  wire logic                      hint_en,
    input  wire logic                      vint_en,
    input  wire logic                      cpu_we,
    input  wire logic [`NGP_PAL_SEL_BIT:0] cpu_addr,
    input  wire logic [15:0]               cpu_din,
    output logic                           pix_cen,
    output ngp_timing_pkg::color_t         rgb,
    output ngp_timing_pkg::hpos_t          pix_x,
    output ngp_timing_pkg::vpos_t          pix_y,
    output logic                           de,
    output logic                           lhbl,
    output logic                           lvbl,
    output logic                           HS,
    output logic                           VS,
    output logic                           hirq,
    output logic                           virq
);
    import ngp_vram_pkg::*;

    ngp_timing_if tim_if ();  // shared timing from the timer.

    logic       rd_en;        // plane read strobe.
    vram_addr_t rd_addr;      // plane read address.
    vram_word_t rd_data;      // memory word, one clock after the strobe.
    pal_index_t plane_pxl;    // plane pixel with its palette.

    assign pix_cen = tim_if.pxl_cen;  // rgb and position are stable at this strobe.
    assign lhbl    = tim_if.lhbl;
    assign lvbl    = tim_if.lvbl;

    ngp_vtimer i_vtimer (
        .clk       (clk),
        .reset     (reset),
        .video_cen (video_cen),
        .hint_en   (hint_en),
        .vint_en   (vint_en),
        .tim       (tim_if.timer),
        .HS        (HS),
        .VS        (VS),
        .hirq      (hirq),
        .virq      (virq)
    );

    ngp_vram i_vram (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    ngp_scroll_plane i_scroll_plane (
        .clk     (clk),
        .reset   (reset),
        .tim     (tim_if.sink),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .pxl_out (plane_pxl)
    );

    ngp_palette i_palette (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .tim      (tim_if.sink),
        .pxl_in   (plane_pxl),
        .rgb      (rgb),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .de       (de)
    );

endmodule

`default_nettype wire

// File: bench/ngp_video_tb.sv
////////////////////////////////////////
// testbench for the video subsystem with
// a write table, pixel model and checks.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ngp_video_defs.svh"

module ngp_video_tb;
    import ngp_timing_pkg::*;

    localparam int LINE_TICKS  = `NGP_HTOTAL_LAST + 1;                  // ticks per line.
    localparam int FRAME_LINES = `NGP_VLAST + 1;                        // lines per frame.
    localparam int CYCLE_LIMIT = 3 * FRAME_LINES * LINE_TICKS * 2 + 2000;
    localparam int CHANGED_IDX = 9;                                     // entry rewritten late.
    localparam int N_WR        = 15;

    // each row is {phase, cpu address, data}, phase 1 goes in after the first frame.
    localparam logic [29:0] WR_TABLE [0:N_WR-1] = '{
        {1'b0, 13'h0000, 16'h0201},   // row 0 col 0, tile 1, palette 2.
        {1'b0, 13'h0001, 16'h1201},   // same tile mirrored left to right.
        {1'b0, 13'h0020, 16'h2201},   // row 1 col 0, mirrored top to bottom.
        {1'b0, 13'h0021, 16'h3102},   // tile 2, palette 1, both mirrors.
        {1'b0, 13'h0808, 16'h1be4},   // tile 1 row 0 holds all four pixel values.
        {1'b0, 13'h080b, 16'h5a5a},
        {1'b0, 13'h080f, 16'hffaa},
        {1'b0, 13'h0810, 16'he41b},
        {1'b0, 13'h0817, 16'h9c36},
        {1'b0, 13'h1005, 16'h0a5c},
        {1'b0, 13'h1008, 16'h0f00},
        {1'b0, 13'h1009, 16'h00f0},
        {1'b0, 13'h100a, 16'h000f},
        {1'b0, 13'h100b, 16'hafff},   // top nibble is dropped by the palette.
        {1'b1, 13'h1009, 16'h0123}    // new colour for the second checked frame.
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        video_cen = 1'b0;
    logic        hint_en;
    logic        vint_en;
    logic        cpu_we;
    logic [12:0] cpu_addr;
    logic [15:0] cpu_din;
    logic        pix_cen;
    color_t      rgb;
    hpos_t       pix_x;
    vpos_t       pix_y;
    logic        de;
    logic        lhbl;
    logic        lvbl;
    logic        HS;
    logic        VS;
    logic        hirq;
    logic        virq;

    logic [15:0] map_m [0:1023];   // model copy of the tile map.
    logic [15:0] pat_m [0:2047];   // model copy of the patterns.
    logic [11:0] pal_m [0:63];     // model copy of the palette.
    logic [31:0] rng = 32'h6830d54f;
    logic run_video = 1'b0;
    logic synced = 1'b0;           // set once the first VS gives the line number.
    logic hs_seen = 1'b0;
    logic lvbl_exp = 1'b1;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;
    logic hirq_q = 1'b0;
    logic virq_q = 1'b0;
    logic lhbl_q = 1'b1;
    int   ticks = 0;               // video_cen ticks since the last HS.
    int   blank_ticks = 0;         // ticks with lhbl low since it last rose.
    int   line = 0;
    int   since_vs = 0;
    int   vs_count = 0;
    int   exp_x = 0;
    int   exp_y = 0;
    int   pix_frames = 0;          // complete frames of checked pixels.
    int   hits = 0;
    int   cycles = 0;

    ngp_video i_ngp_video (
        .clk(clk), .reset(reset), .video_cen(video_cen),
        .hint_en(hint_en), .vint_en(vint_en),
        .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .pix_cen(pix_cen), .rgb(rgb), .pix_x(pix_x), .pix_y(pix_y), .de(de),
        .lhbl(lhbl), .lvbl(lvbl), .HS(HS), .VS(VS), .hirq(hirq), .virq(virq)
    );

    always #2 clk = ~clk;          // 4 ns period.

    always @(posedge clk) begin
        #1;
        video_cen = run_video && !video_cen;  // one video tick every other clock.
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            abort_run($sformatf("[FAIL] %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, want));
        end
    endtask

    // one write per clock, the model follows the same address split as the memories.
    task automatic cpu_write(input logic [12:0] addr, input logic [15:0] data);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_din  = data;
        if (addr[12]) pal_m[addr[5:0]] = data[11:0];
        else if (addr[11]) pat_m[addr[10:0]] = data;
        else map_m[addr[9:0]] = data;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    task automatic apply_table(input logic phase);
        for (int i = 0; i < N_WR; i++) begin
            if (WR_TABLE[i][29] == phase) cpu_write(WR_TABLE[i][28:16], WR_TABLE[i][15:0]);
        end
    endtask

    always @(posedge clk) begin
        if (run_video) begin
            cycles++;
            if (cycles > CYCLE_LIMIT) abort_run("the run timed out waiting for frames");
        end
    end

    // line timing, sync, blanking and interrupts, sampled away from the clock edge.
    always @(negedge clk) begin : timing_mon
        logic hs_rise;
        logic hb_rise;
        logic hi_rise;
        logic vi_rise;
        hs_rise = HS && !hs_q;
        hb_rise = lhbl && !lhbl_q;
        hi_rise = hirq && !hirq_q;
        vi_rise = virq && !virq_q;
        if (hs_rise) begin
            if (hs_seen) compare(ticks, LINE_TICKS, "video ticks between HS pulses");
            hs_seen  = 1'b1;
            ticks    = 0;
            line     = (line == `NGP_VLAST) ? 0 : line + 1;
            since_vs++;
        end
        if (hb_rise) begin
            compare(blank_ticks, `NGP_HBEND - `NGP_HBSTART, "lhbl low time");
            blank_ticks = 0;
        end
        if (VS && !vs_q) begin
            if (synced) compare(since_vs, FRAME_LINES, "HS pulses between VS pulses");
            synced   = 1'b1;
            since_vs = 0;
            line     = `NGP_VS_START;  // VS rises on the sync of this line.
            vs_count++;
        end
        if (!VS && vs_q) compare(since_vs, `NGP_VS_END - `NGP_VS_START, "VS width in lines");
        if (synced) begin
            if (hs_rise) lvbl_exp = !(line >= `NGP_VBSTART && line < `NGP_VLAST);
            compare(lvbl, lvbl_exp, "lvbl level");
            compare(hi_rise, hs_rise && hint_en &&
                    (line <= `NGP_HIRQ_LAST || line == `NGP_VLAST), "hirq rise");
            compare(vi_rise, hs_rise && vint_en && line == `NGP_VBSTART, "virq rise");
        end
        if (video_cen) ticks++;
        if (video_cen && !lhbl) blank_ticks++;
        hs_q   = HS;
        lhbl_q = lhbl;
        hirq_q = hirq;
        virq_q = virq;
        vs_q   = VS;
    end

    // every pixel strobe is compared with the model, positions must come in raster order.
    always @(negedge clk) begin : pixel_mon
        logic [15:0] ent;
        logic [15:0] row;
        int fine_y;
        int px;
        int idx;
        if (pix_cen && synced) begin
            if (de) begin
                compare(pix_x, exp_x, "pixel column");
                compare(pix_y, exp_y, "pixel line");
                ent    = map_m[(exp_y / 8) * 32 + exp_x / 8];
                fine_y = ent[13] ? 7 - exp_y % 8 : exp_y % 8;   // vflip.
                row    = pat_m[int'(ent[7:0]) * 8 + fine_y];
                px     = ent[12] ? 7 - exp_x % 8 : exp_x % 8;   // hflip.
                idx    = int'(ent[11:8]) * 4 + (int'(row >> (14 - 2 * px)) & 3);
                compare(rgb, pal_m[idx], "pixel colour");
                if (pix_frames == 1 && idx == CHANGED_IDX) hits++;
                exp_x++;
                if (exp_x == `NGP_VIS_W) begin
                    exp_x = 0;
                    exp_y++;
                end
                if (exp_y == `NGP_VIS_H) begin
                    exp_y = 0;
                    pix_frames++;
                end
            end else begin
                compare(rgb, 0, "rgb outside the display area");
            end
        end
    end

    initial begin
        reset    = 1'b1;
        hint_en  = 1'b1;
        vint_en  = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 1024; i++) begin  // whole map, tiles 0 to 63.
            rng = lcg_next(rng);
            cpu_write(13'(i), {2'b00, rng[31:30], rng[27:24], 2'b00, rng[21:16]});
        end
        for (int i = 0; i < 512; i++) begin   // patterns of those 64 tiles.
            rng = lcg_next(rng);
            cpu_write(13'(`NGP_PAT_BASE + i), rng[31:16]);
        end
        for (int i = 0; i < 64; i++) begin
            rng = lcg_next(rng);
            cpu_write(13'h1000 | 13'(i), {4'h0, rng[27:16]});
        end
        apply_table(1'b0);
        run_video = 1'b1;
        wait (pix_frames >= 1);               // now in vertical blanking.
        @(posedge clk);
        #1;
        apply_table(1'b1);
        wait (vs_count >= 2);
        @(posedge clk);
        #1;
        hint_en = 1'b0;                       // a whole frame without interrupts.
        vint_en = 1'b0;
        wait (vs_count >= 3);
        compare(pix_frames, 2, "checked frames");
        compare(hits != 0, 1, "pixels using the rewritten palette entry");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/ngp_timing_pkg.sv
hdl/ngp_vram_pkg.sv
hdl/ngp_timing_if.sv
hdl/ngp_vtimer.sv
hdl/ngp_vram.sv
hdl/ngp_scroll_plane.sv
hdl/ngp_palette.sv
hdl/ngp_video.sv
bench/ngp_video_tb.sv
